// File: Makefile
# Verilator build and run of the RV32I ALU slice testbench

BIN := obj_dir/Valu_core_tb

$(BIN): src.f $(wildcard hdl/*.sv verif/*.sv include/*.svh)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module alu_core_tb -f src.f

.PHONY: run clean

# Pass only when the pass line shows up in the simulator output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

// File: hdl/alu_core_top.sv
/*
 * RV32I ALU slice top
 * Pre-decode buffer, issue, execute and writeback in a row
 */
`default_nettype none
`include "rv_alu_macros.svh"

module alu_core_top (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   flush,
    input  logic [31:0]            instruction,
    input  logic [`XLEN-1:0]       pc,
    input  logic                   push,
    output logic                   wb_valid,
    output logic [`REG_ADDR_W-1:0] wb_rd,
    output logic [`XLEN-1:0]       wb_data,
    output logic                   drop
);
    import rv_alu_pkg::*;

    // Buffer to issue
    logic                   fb_valid;
    fetch_buffer_packet_t   fb;
    logic                   pop;
    // Register file
    logic [`REG_ADDR_W-1:0] rs1_addr;
    logic [`REG_ADDR_W-1:0] rs2_addr;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;
    // Issue to execute
    logic                   issue_valid;
    logic [`REG_ADDR_W-1:0] issue_rd;
    logic [`XLEN-1:0]       issue_op_a;
    logic [`XLEN-1:0]       issue_op_b;
    logic                   issue_sub;
    alu_logic_op_t          issue_logic_op;
    fn3_t                   issue_fn3;
    logic                   issue_shift_arith;
    // Execute to writeback
    logic                   ex_valid;
    logic [`REG_ADDR_W-1:0] ex_rd;
    logic [`XLEN-1:0]       ex_result;

    pre_decode u_pre_decode (
        .clk, .arst_n, .flush, .instruction, .pc, .push, .pop, .fb_valid, .fb
    );

    issue_decode u_issue_decode (
        .clk, .arst_n, .flush, .fb_valid, .fb, .rs1_data, .rs2_data,
        .ex_valid, .ex_rd, .wb_valid, .wb_rd, .pop, .rs1_addr, .rs2_addr,
        .issue_valid, .issue_rd, .issue_op_a, .issue_op_b, .issue_sub,
        .issue_logic_op, .issue_fn3, .issue_shift_arith, .drop
    );

    alu_execute u_alu_execute (
        .clk, .arst_n, .flush, .issue_valid, .issue_rd, .issue_op_a, .issue_op_b,
        .issue_sub, .issue_logic_op, .issue_fn3, .issue_shift_arith,
        .ex_valid, .ex_rd, .ex_result
    );

    writeback_result u_writeback_result (
        .clk, .arst_n, .ex_valid, .ex_rd, .ex_result, .rs1_addr, .rs2_addr,
        .rs1_data, .rs2_data, .wb_valid, .wb_rd, .wb_data
    );

endmodule

`default_nettype wire

// File: hdl/alu_execute.sv
/*
 * Execute stage
 * Adder/subtractor, shifter, compare and logic unit, registered result
 */
`default_nettype none
`include "rv_alu_macros.svh"

module alu_execute (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      flush,
    input  logic                      issue_valid,
    input  logic [`REG_ADDR_W-1:0]    issue_rd,
    input  logic [`XLEN-1:0]          issue_op_a,
    input  logic [`XLEN-1:0]          issue_op_b,
    input  logic                      issue_sub,
    input  rv_alu_pkg::alu_logic_op_t issue_logic_op,
    input  rv_alu_pkg::fn3_t          issue_fn3,
    input  logic                      issue_shift_arith,
    output logic                      ex_valid,
    output logic [`REG_ADDR_W-1:0]    ex_rd,
    output logic [`XLEN-1:0]          ex_result
);
    import rv_alu_pkg::*;

    logic [`XLEN:0]   add_sub;       // Carry out on top
    logic [`XLEN-1:0] shl;
    logic [`XLEN-1:0] shr;
    logic             slt;
    logic             sltu;
    logic [`XLEN-1:0] logic_result;
    logic [`XLEN-1:0] result;

    // a - b as a + ~b + 1
    assign add_sub = {1'b0, issue_op_a} + {1'b0, issue_op_b ^ {`XLEN{issue_sub}}}
                     + (`XLEN+1)'(issue_sub);
    assign sltu    = !add_sub[`XLEN];  // Borrow
    assign slt     = (issue_op_a[`XLEN-1] != issue_op_b[`XLEN-1]) ? issue_op_a[`XLEN-1]
                                                                 : add_sub[`XLEN-1];

    assign shl = issue_op_a << issue_op_b[4:0];
    assign shr = `XLEN'($signed({issue_shift_arith & issue_op_a[`XLEN-1], issue_op_a})
                 >>> issue_op_b[4:0]);

    always_comb begin
        case (issue_logic_op)
            ALU_LOGIC_XOR : logic_result = issue_op_a ^ issue_op_b;
            ALU_LOGIC_OR  : logic_result = issue_op_a | issue_op_b;
            ALU_LOGIC_AND : logic_result = issue_op_a & issue_op_b;
            default       : logic_result = add_sub[`XLEN-1:0];
        endcase
        case (issue_fn3)
            SLL_fn3  : result = shl;
            SLT_fn3  : result = `XLEN'(slt);
            SLTU_fn3 : result = `XLEN'(sltu);
            SRA_fn3  : result = shr;
            default  : result = logic_result;  // ADD, SUB, XOR, OR, AND
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            ex_valid <= 1'b0;
        else
            ex_valid <= issue_valid && !flush;
    end

    always_ff @(posedge clk) begin
        ex_rd     <= issue_rd;
        ex_result <= result;
    end

endmodule

`default_nettype wire

// File: hdl/fetch_fifo.sv
/*
 * Fetch buffer overflow store
 * Circular FIFO of pre-decoded packets, synchronous flush
 */
`default_nettype none
`include "rv_alu_macros.svh"

module fetch_fifo (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             flush,
    input  logic                             push,
    input  logic                             pop,
    input  rv_alu_pkg::fetch_buffer_packet_t data_in,
    output rv_alu_pkg::fetch_buffer_packet_t data_out,
    output logic                             valid,
    output logic                             full
);
    import rv_alu_pkg::*;

    localparam int PTR_W = $clog2(`FETCH_BUFFER_DEPTH);

    fetch_buffer_packet_t mem [`FETCH_BUFFER_DEPTH];
    logic [PTR_W-1:0]     rd_ptr;
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W:0]       count;   // 0 to DEPTH

    assign data_out = mem[rd_ptr];  // Head, read ahead
    assign valid    = (count != '0);
    assign full     = (count == (PTR_W+1)'(`FETCH_BUFFER_DEPTH));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;   // Depth is a power of two, wraps
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + (PTR_W+1)'(push) - (PTR_W+1)'(pop);
        end
    end

    // Storage, no reset
    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= data_in;
    end

    ////////////////////
    // Assertions
    push_full_a : assert property (@(posedge clk) disable iff (!arst_n || flush)
        push && full |-> pop);
    pop_empty_a : assert property (@(posedge clk) disable iff (!arst_n || flush)
        pop |-> valid);

endmodule

`default_nettype wire

// File: hdl/issue_decode.sv
/*
 * Issue stage
 * Register read, immediates, operand select and a scoreboard stall
 * against results still in flight, then one issue per cycle
 */
`default_nettype none
`include "rv_alu_macros.svh"

module issue_decode (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             flush,
    input  logic                             fb_valid,
    input  rv_alu_pkg::fetch_buffer_packet_t fb,
    input  logic [`XLEN-1:0]                 rs1_data,
    input  logic [`XLEN-1:0]                 rs2_data,
    input  logic                             ex_valid,
    input  logic [`REG_ADDR_W-1:0]           ex_rd,
    input  logic                             wb_valid,
    input  logic [`REG_ADDR_W-1:0]           wb_rd,
    output logic                             pop,
    output logic [`REG_ADDR_W-1:0]           rs1_addr,
    output logic [`REG_ADDR_W-1:0]           rs2_addr,
    output logic                             issue_valid,
    output logic [`REG_ADDR_W-1:0]           issue_rd,
    output logic [`XLEN-1:0]                 issue_op_a,
    output logic [`XLEN-1:0]                 issue_op_b,
    output logic                             issue_sub,
    output rv_alu_pkg::alu_logic_op_t        issue_logic_op,
    output rv_alu_pkg::fn3_t                 issue_fn3,
    output logic                             issue_shift_arith,
    output logic                             drop
);
    import rv_alu_pkg::*;

    logic [`REG_ADDR_W-1:0] rd_addr;
    logic [`XLEN-1:0]       imm_i;
    logic [`XLEN-1:0]       imm_u;
    logic [`XLEN-1:0]       op_a;
    logic [`XLEN-1:0]       op_b;
    logic                   rs1_hazard;
    logic                   rs2_hazard;
    fn3_t                   fn3;

    assign rs1_addr = fb.instruction[19:15];
    assign rs2_addr = fb.instruction[24:20];
    assign rd_addr  = fb.uses_rd ? fb.instruction[11:7] : '0;  // x0 means no write

    assign imm_i = {{(`XLEN-12){fb.instruction[31]}}, fb.instruction[31:20]};
    assign imm_u = {fb.instruction[31:12], 12'b0};

    ////////////////////
    // Scoreboard
    // Execute, result register and writeback
    assign rs1_hazard = fb.uses_rs1 && (rs1_addr != '0) &&
                        ((issue_valid && (issue_rd == rs1_addr)) ||
                         (ex_valid && (ex_rd == rs1_addr)) ||
                         (wb_valid && (wb_rd == rs1_addr)));
    assign rs2_hazard = fb.uses_rs2 && (rs2_addr != '0) &&
                        ((issue_valid && (issue_rd == rs2_addr)) ||
                         (ex_valid && (ex_rd == rs2_addr)) ||
                         (wb_valid && (wb_rd == rs2_addr)));

    assign pop = fb_valid && !rs1_hazard && !rs2_hazard && !flush;

    ////////////////////
    // Operands
    always_comb begin
        case (fb.alu_rs1_sel)
            ALU_RS1_RF : op_a = rs1_data;
            ALU_RS1_PC : op_a = fb.pc;
            default    : op_a = '0;
        endcase
        case (fb.alu_rs2_sel)
            ALU_RS2_RF        : op_b = rs2_data;
            ALU_RS2_ARITH_IMM : op_b = imm_i;       // Shamt in the low 5 bits
            ALU_RS2_LUI_AUIPC : op_b = imm_u;
            default           : op_b = `XLEN'(4);   // Link value pc+4
        endcase
    end

    // fn3 field is immediate bits outside the ARITH forms
    assign fn3 = (fb.alu_rs1_sel == ALU_RS1_RF) ? fn3_t'(fb.instruction[14:12]) : ADD_SUB_fn3;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            issue_valid <= 1'b0;
            drop        <= 1'b0;
        end else if (flush) begin
            issue_valid <= 1'b0;
            drop        <= 1'b0;
        end else begin
            issue_valid <= pop && fb.alu_request;
            drop        <= pop && !fb.alu_request;   // Consumed, never executed
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            issue_rd          <= rd_addr;
            issue_op_a        <= op_a;
            issue_op_b        <= op_b;
            issue_sub         <= fb.alu_sub;
            issue_logic_op    <= fb.alu_logic_op;
            issue_fn3         <= fn3;
            issue_shift_arith <= fb.instruction[30];  // SRA vs SRL
        end
    end

    // Stalled entry stays put until popped
    fb_hold_a : assert property (@(posedge clk) disable iff (!arst_n)
        fb_valid && !pop && !flush |=> fb_valid && $stable(fb));

endmodule

`default_nettype wire

// File: hdl/pre_decode.sv
/*
 * Pre-decode and fetch buffer
 * Classifies each fetched word, holds it in an output register toward
 * decode, overflow entries wait in the FIFO behind it
 */
`default_nettype none
`include "rv_alu_macros.svh"

module pre_decode (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             flush,
    input  logic [31:0]                      instruction,
    input  logic [`XLEN-1:0]                 pc,
    input  logic                             push,
    input  logic                             pop,
    output logic                             fb_valid,
    output rv_alu_pkg::fetch_buffer_packet_t fb
);
    import rv_alu_pkg::*;

    opcode_t              opcode_trimmed;
    fn3_t                 fn3;
    logic                 csr_imm_op;
    logic                 sys_op;
    logic                 sub_instruction;
    logic                 non_mul_div_arith_op;
    alu_logic_op_t        logic_op;
    alu_rs1_sel_t         rs1_sel;
    alu_rs2_sel_t         rs2_sel;
    fetch_buffer_packet_t data_in;
    fetch_buffer_packet_t fifo_out;
    fetch_buffer_packet_t new_data;
    logic                 fifo_push;
    logic                 fifo_pop;
    logic                 fifo_valid;

    ////////////////////
    // Buffer
    // Into the FIFO only when the output register stays occupied
    assign fifo_push = push && ((fb_valid && !pop) || fifo_valid);
    assign fifo_pop  = pop && fifo_valid;
    assign new_data  = fifo_valid ? fifo_out : data_in;  // Bypass when store empty

    always_ff @(posedge clk) begin
        if (!fb_valid || pop)
            fb <= new_data;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            fb_valid <= 1'b0;
        else if (flush)
            fb_valid <= 1'b0;
        else if (push)
            fb_valid <= 1'b1;            // Set over clear
        else if (pop && !fifo_valid)
            fb_valid <= 1'b0;
    end

    fetch_fifo fb_fifo (
        .clk      (clk),
        .arst_n   (arst_n),
        .flush    (flush),
        .push     (fifo_push),
        .pop      (fifo_pop),
        .data_in  (data_in),
        .data_out (fifo_out),
        .valid    (fifo_valid),
        .full     ()
    );

    ////////////////////
    // Classification
    assign opcode_trimmed = opcode_t'(instruction[6:2]);
    assign fn3            = fn3_t'(instruction[14:12]);
    assign csr_imm_op     = (opcode_trimmed == SYSTEM_T) && fn3[2];
    assign sys_op         = (opcode_trimmed == SYSTEM_T) && (fn3 == ADD_SUB_fn3);

    assign data_in.instruction = instruction;
    assign data_in.pc          = pc;
    assign data_in.uses_rs1    = !((opcode_trimmed inside {LUI_T, AUIPC_T, JAL_T, FENCE_T})
                                   || csr_imm_op || sys_op);
    assign data_in.uses_rs2    = opcode_trimmed inside {BRANCH_T, STORE_T, ARITH_T, AMO_T};
    assign data_in.uses_rd     = !((opcode_trimmed inside {BRANCH_T, STORE_T, FENCE_T})
                                   || sys_op);

    // SUB only in the register form, bit 5 of opcode
    assign sub_instruction = (fn3 == ADD_SUB_fn3) && instruction[30] && instruction[5];
    assign data_in.alu_sub = !instruction[2] &&   // Bit 2 set for LUI, AUIPC, JAL, JALR
                             ((fn3 inside {SLT_fn3, SLTU_fn3}) || sub_instruction);

    // Bit 25 marks M-extension in the register form
    assign non_mul_div_arith_op = (opcode_trimmed == ARITH_T) && !instruction[25];
    assign data_in.alu_request  = non_mul_div_arith_op ||
                                  (opcode_trimmed inside {ARITH_IMM_T, AUIPC_T, LUI_T,
                                                          JAL_T, JALR_T});

    always_comb begin
        case (fn3)
            XOR_fn3 : logic_op = ALU_LOGIC_XOR;
            OR_fn3  : logic_op = ALU_LOGIC_OR;
            AND_fn3 : logic_op = ALU_LOGIC_AND;
            default : logic_op = ALU_LOGIC_ADD;   // Adds, compares, shifts
        endcase
        if (instruction[2])
            logic_op = ALU_LOGIC_ADD;             // Upper immediates and links add
    end

    always_comb begin
        if (opcode_trimmed inside {ARITH_T, ARITH_IMM_T})
            rs1_sel = ALU_RS1_RF;
        else if (opcode_trimmed inside {JAL_T, JALR_T, AUIPC_T})
            rs1_sel = ALU_RS1_PC;
        else
            rs1_sel = ALU_RS1_ZERO;

        if (opcode_trimmed inside {LUI_T, AUIPC_T})
            rs2_sel = ALU_RS2_LUI_AUIPC;
        else if (opcode_trimmed == ARITH_IMM_T)
            rs2_sel = ALU_RS2_ARITH_IMM;
        else if (opcode_trimmed inside {JAL_T, JALR_T})
            rs2_sel = ALU_RS2_JAL_JALR;
        else
            rs2_sel = ALU_RS2_RF;
    end

    assign data_in.alu_logic_op = logic_op;
    assign data_in.alu_rs1_sel  = rs1_sel;
    assign data_in.alu_rs2_sel  = rs2_sel;

endmodule

`default_nettype wire

// File: hdl/rv_alu_pkg.sv
/*
 * RV32I ALU slice types
 * Opcode and function encodings, ALU controls, fetch buffer packet
 */
`default_nettype none
`include "rv_alu_macros.svh"

package rv_alu_pkg;

    // Opcode bits [6:2], the low two bits are always 2'b11
    typedef enum logic [4:0] {
        LOAD_T      = 5'b00000,
        FENCE_T     = 5'b00011,
        ARITH_IMM_T = 5'b00100,
        AUIPC_T     = 5'b00101,
        STORE_T     = 5'b01000,
        AMO_T       = 5'b01011,
        ARITH_T     = 5'b01100,
        LUI_T       = 5'b01101,
        BRANCH_T    = 5'b11000,
        JALR_T      = 5'b11001,
        JAL_T       = 5'b11011,
        SYSTEM_T    = 5'b11100
    } opcode_t;

    typedef enum logic [2:0] {
        ADD_SUB_fn3 = 3'b000,
        SLL_fn3     = 3'b001,
        SLT_fn3     = 3'b010,
        SLTU_fn3    = 3'b011,
        XOR_fn3     = 3'b100,
        SRA_fn3     = 3'b101, // SRL too, bit 30 picks
        OR_fn3      = 3'b110,
        AND_fn3     = 3'b111
    } fn3_t;

    typedef enum logic [1:0] {
        ALU_LOGIC_ADD = 2'b00, // Adder path
        ALU_LOGIC_XOR = 2'b01,
        ALU_LOGIC_OR  = 2'b10,
        ALU_LOGIC_AND = 2'b11
    } alu_logic_op_t;

    typedef enum logic [1:0] {
        ALU_RS1_RF   = 2'b00,
        ALU_RS1_PC   = 2'b01,
        ALU_RS1_ZERO = 2'b10  // LUI
    } alu_rs1_sel_t;

    typedef enum logic [1:0] {
        ALU_RS2_RF        = 2'b00,
        ALU_RS2_ARITH_IMM = 2'b01,
        ALU_RS2_LUI_AUIPC = 2'b10,
        ALU_RS2_JAL_JALR  = 2'b11  // Constant 4, link value
    } alu_rs2_sel_t;

    // Pre-decoded entry, one per fetched word
    typedef struct packed {
        logic [31:0]        instruction;
        logic [`XLEN-1:0]   pc;
        logic               uses_rs1;
        logic               uses_rs2;
        logic               uses_rd;
        logic               alu_request;
        logic               alu_sub;
        alu_logic_op_t      alu_logic_op;
        alu_rs1_sel_t       alu_rs1_sel;
        alu_rs2_sel_t       alu_rs2_sel;
    } fetch_buffer_packet_t;

endpackage

`default_nettype wire

// File: hdl/writeback_result.sv
/*
 * Register file and writeback report
 * 31 registers, two combinational reads, x0 hardwired to zero
 */
`default_nettype none
`include "rv_alu_macros.svh"

module writeback_result (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   ex_valid,
    input  logic [`REG_ADDR_W-1:0] ex_rd,
    input  logic [`XLEN-1:0]       ex_result,
    input  logic [`REG_ADDR_W-1:0] rs1_addr,
    input  logic [`REG_ADDR_W-1:0] rs2_addr,
    output logic [`XLEN-1:0]       rs1_data,
    output logic [`XLEN-1:0]       rs2_data,
    output logic                   wb_valid,
    output logic [`REG_ADDR_W-1:0] wb_rd,
    output logic [`XLEN-1:0]       wb_data
);
    localparam int NUM_REGS = 1 << `REG_ADDR_W;

    logic [`XLEN-1:0] regs [1:NUM_REGS-1];  // No storage for x0
    logic             write_en;

    assign write_en = ex_valid && (ex_rd != '0);

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < NUM_REGS; i++)
                regs[i] <= '0;
            wb_valid <= 1'b0;
        end else begin
            if (write_en)
                regs[ex_rd] <= ex_result;
            wb_valid <= write_en;   // Report lines up with the update
        end
    end

    always_ff @(posedge clk) begin
        wb_rd   <= ex_rd;
        wb_data <= ex_result;
    end

endmodule

`default_nettype wire

// File: include/rv_alu_macros.svh
/*
 * RV32I ALU slice constants
 * Buffer depth, register addressing and datapath width
 */
`ifndef RV_ALU_MACROS_SVH
`define RV_ALU_MACROS_SVH

// Entries in the store behind the fetch buffer output register
`define FETCH_BUFFER_DEPTH 4

`define XLEN 32       // Datapath width
`define REG_ADDR_W 5  // 32 architectural registers

`endif

// File: src.f
+incdir+include
hdl/rv_alu_pkg.sv
hdl/fetch_fifo.sv
hdl/pre_decode.sv
hdl/issue_decode.sv
hdl/alu_execute.sv
hdl/writeback_result.sv
hdl/alu_core_top.sv
verif/alu_core_tb.sv

// File: verif/alu_core_tb.sv
/*
 * Testbench for the RV32I ALU slice
 * Directed tests against a register model, a writeback monitor
 * and a watchdog scaled by the number of pushed instructions
 */
`default_nettype none
`include "rv_alu_macros.svh"

module alu_core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    // RV32I major opcodes
    localparam logic [6:0] OP_LUI    = 7'h37;
    localparam logic [6:0] OP_AUIPC  = 7'h17;
    localparam logic [6:0] OP_JAL    = 7'h6f;
    localparam logic [6:0] OP_JALR   = 7'h67;
    localparam logic [6:0] OP_IMM    = 7'h13;
    localparam logic [6:0] OP_REG    = 7'h33;
    localparam logic [6:0] OP_BRANCH = 7'h63;
    localparam logic [6:0] OP_STORE  = 7'h23;
    localparam logic [6:0] OP_LOAD   = 7'h03;
    localparam logic [6:0] OP_FENCE  = 7'h0f;

    logic                   clk;
    logic                   arst_n;
    logic                   flush;
    logic [31:0]            instruction;
    logic [`XLEN-1:0]       pc;
    logic                   push;
    logic                   wb_valid;
    logic [`REG_ADDR_W-1:0] wb_rd;
    logic [`XLEN-1:0]       wb_data;
    logic                   drop;

    // Reference state
    logic [31:0] model_regs [32];
    logic [31:0] exp_rd [$];      // Expected writes, program order
    logic [31:0] exp_data [$];
    logic [31:0] next_pc;
    int          drops_expected;
    int          drops_seen;
    int          pending;         // Pushes since the last drain
    int          push_count;

    alu_core_top uut (
        .clk, .arst_n, .flush, .instruction, .pc, .push,
        .wb_valid, .wb_rd, .wb_data, .drop
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // 20 ns period
    end

    ////////////////////
    // Reporting
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    // Writeback and drop monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (arst_n && wb_valid) begin
            if (exp_rd.size() == 0)
                fail_run($sformatf("Unexpected writeback to x%0d", wb_rd));
            else begin
                check("wb_rd", 32'(wb_rd), exp_rd.pop_front());
                check("wb_data", wb_data, exp_data.pop_front());
            end
        end
        if (arst_n && drop) begin
            drops_seen++;
            if (drops_seen > drops_expected)
                fail_run("Drop pulse seen with no non-ALU instruction outstanding");
        end
    end

    // Budget grows with every push, so a stuck pipeline runs out
    initial begin : watchdog
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > 200 * (push_count + 1))
                fail_run("Timeout: the DUT stopped making progress");
        end
    end

    ////////////////////
    // Encoders and model
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    // ALU work per RV32I, M-extension words excluded
    function automatic bit is_alu(input logic [31:0] w);
        case (w[6:0])
            OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_IMM : return 1'b1;
            OP_REG  : return !w[25];
            default : return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] reference(input logic [31:0] w, input logic [31:0] pc_v,
                                              input logic [31:0] a, input logic [31:0] b);
        logic [31:0] imm;
        logic [31:0] opnd;
        logic [31:0] sra_v;
        logic [4:0]  sh;
        imm = {{20{w[31]}}, w[31:20]};
        case (w[6:0])
            OP_LUI          : return {w[31:12], 12'h000};
            OP_AUIPC        : return pc_v + {w[31:12], 12'h000};
            OP_JAL, OP_JALR : return pc_v + 32'd4;   // Link only
            default         : ;
        endcase
        opnd  = (w[6:0] == OP_IMM) ? imm : b;
        sh    = opnd[4:0];
        sra_v = $signed(a) >>> sh;
        case (w[14:12])
            3'd0    : return (w[6:0] == OP_REG && w[30]) ? a - opnd : a + opnd;
            3'd1    : return a << sh;
            3'd2    : return ($signed(a) < $signed(opnd)) ? 32'd1 : 32'd0;
            3'd3    : return (a < opnd) ? 32'd1 : 32'd0;
            3'd4    : return a ^ opnd;
            3'd5    : return w[30] ? sra_v : a >> sh;   // SRA or SRL
            3'd6    : return a | opnd;
            default : return a & opnd;
        endcase
    endfunction

    ////////////////////
    // Drivers
    task automatic drain();
        @(posedge clk);
        #1;
        push = 1'b0;
        while (exp_rd.size() != 0 || drops_seen != drops_expected)
            @(posedge clk);
        pending = 0;
    endtask

    // completes low for words that a flush will cancel
    task automatic push_instr(input logic [31:0] word, input bit completes);
        logic [4:0]  rd;
        logic [31:0] res;
        if (pending == `FETCH_BUFFER_DEPTH + 1)
            drain();                          // Never overfill the buffer
        rd = word[11:7];
        if (completes) begin
            if (!is_alu(word))
                drops_expected++;
            else if (rd != 5'd0) begin
                res = reference(word, next_pc, model_regs[word[19:15]], model_regs[word[24:20]]);
                model_regs[rd] = res;
                exp_rd.push_back(32'(rd));
                exp_data.push_back(res);
            end
        end
        @(posedge clk);
        #1;
        instruction = word;
        pc          = next_pc;
        push        = 1'b1;
        next_pc     += 32'd4;
        pending++;
        push_count++;
    endtask

    // LUI then ADDI, upper part rounded for the sign-extended low half
    task automatic load_reg(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] upper;
        upper = value + 32'h800;
        push_instr(u_type(upper[31:12], rd, OP_LUI), 1'b1);
        push_instr(i_type(value[11:0], rd, 3'd0, rd, OP_IMM), 1'b1);
    endtask

    ////////////////////
    // Tests
    task automatic imm_arith();
        load_reg(5'd1, $urandom());
        load_reg(5'd2, $urandom() | 32'h8000_0000);   // Negative source for SRAI
        push_instr(i_type(12'($urandom()), 5'd1, 3'd0, 5'd3, OP_IMM), 1'b1);  // ADDI
        push_instr(i_type(12'hffb, 5'd2, 3'd2, 5'd4, OP_IMM), 1'b1);          // SLTI -5
        push_instr(i_type(12'($urandom()), 5'd1, 3'd3, 5'd5, OP_IMM), 1'b1);  // SLTIU
        push_instr(i_type(12'($urandom()), 5'd1, 3'd4, 5'd6, OP_IMM), 1'b1);  // XORI
        push_instr(i_type(12'($urandom()), 5'd2, 3'd6, 5'd7, OP_IMM), 1'b1);  // ORI
        push_instr(i_type(12'($urandom()), 5'd1, 3'd7, 5'd8, OP_IMM), 1'b1);  // ANDI
        push_instr(i_type({7'h00, 5'($urandom())}, 5'd1, 3'd1, 5'd9, OP_IMM), 1'b1);
        push_instr(i_type({7'h00, 5'($urandom())}, 5'd2, 3'd5, 5'd10, OP_IMM), 1'b1);
        push_instr(i_type({7'h20, 5'($urandom())}, 5'd2, 3'd5, 5'd11, OP_IMM), 1'b1);
        drain();
    endtask

    task automatic reg_reg_ops();
        for (int round = 0; round < 3; round++) begin
            load_reg(5'd1, $urandom());
            load_reg(5'd2, $urandom());
            for (int f = 0; f < 8; f++)
                push_instr(r_type(7'h00, 5'd2, 5'd1, 3'(f), 5'(3 + f), OP_REG), 1'b1);
            push_instr(r_type(7'h20, 5'd2, 5'd1, 3'd0, 5'd11, OP_REG), 1'b1);  // SUB
            push_instr(r_type(7'h20, 5'd2, 5'd1, 3'd5, 5'd12, OP_REG), 1'b1);  // SRA
            // Back to back dependencies, each one stalls
            push_instr(r_type(7'h00, 5'd12, 5'd11, 3'd0, 5'd13, OP_REG), 1'b1);
            push_instr(r_type(7'h20, 5'd3, 5'd13, 3'd0, 5'd14, OP_REG), 1'b1);
            push_instr(r_type(7'h20, 5'd2, 5'd14, 3'd5, 5'd15, OP_REG), 1'b1);
            push_instr(r_type(7'h00, 5'd14, 5'd15, 3'd6, 5'd16, OP_REG), 1'b1);
            drain();
        end
    endtask

    task automatic upper_and_link();
        load_reg(5'd1, $urandom());
        push_instr(u_type(20'($urandom()), 5'd17, OP_LUI), 1'b1);
        push_instr(u_type(20'($urandom()), 5'd18, OP_AUIPC), 1'b1);
        push_instr(u_type(20'($urandom()), 5'd19, OP_JAL), 1'b1);  // No redirect
        push_instr(i_type(12'($urandom()), 5'd1, 3'd0, 5'd20, OP_JALR), 1'b1);
        push_instr(r_type(7'h00, 5'd19, 5'd18, 3'd0, 5'd21, OP_REG), 1'b1);
        drain();
    endtask

    task automatic non_alu_drops();
        push_instr(r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd8, OP_BRANCH), 1'b1);  // BEQ
        push_instr(r_type(7'h00, 5'd2, 5'd1, 3'd2, 5'd4, OP_STORE), 1'b1);   // SW
        push_instr(i_type(12'h010, 5'd1, 3'd2, 5'd21, OP_LOAD), 1'b1);      // LW
        push_instr(i_type(12'h0ff, 5'd0, 3'd0, 5'd0, OP_FENCE), 1'b1);
        push_instr(r_type(7'h01, 5'd2, 5'd1, 3'd0, 5'd22, OP_REG), 1'b1);    // MUL
        push_instr(i_type(12'h123, 5'd1, 3'd0, 5'd0, OP_IMM), 1'b1);        // Into x0
        push_instr(r_type(7'h00, 5'd0, 5'd0, 3'd0, 5'd23, OP_REG), 1'b1);    // Reads x0
        push_instr(r_type(7'h00, 5'd1, 5'd0, 3'd6, 5'd21, OP_REG), 1'b1);
        drain();
    endtask

    task automatic independent_bursts();
        for (int b = 0; b < 3; b++) begin
            drain();
            for (int i = 0; i < `FETCH_BUFFER_DEPTH + 1; i++)
                push_instr(i_type(12'($urandom()), 5'(24 + i), i[0] ? 3'd4 : 3'd6,
                                  5'(24 + i), OP_IMM), 1'b1);
            drain();
        end
    endtask

    task automatic flush_pending();
        push_instr(i_type(12'h05a, 5'd0, 3'd0, 5'd10, OP_IMM), 1'b1);     // Popped early
        push_instr(r_type(7'h00, 5'd10, 5'd10, 3'd0, 5'd11, OP_REG), 1'b0); // Stalls on x10
        push_instr(r_type(7'h20, 5'd10, 5'd11, 3'd0, 5'd12, OP_REG), 1'b0);
        push_instr(i_type(12'h7ff, 5'd0, 3'd6, 5'd13, OP_IMM), 1'b0);
        @(posedge clk);
        #1;
        push = 1'b0;
        @(negedge clk);
        while (!wb_valid)
            @(negedge clk);
        @(posedge clk);
        #1;
        flush = 1'b1;                // One cycle, buffer still holds the rest
        @(posedge clk);
        #1;
        flush   = 1'b0;
        pending = 0;
        drain();
        // Same words again, nothing cancelled now
        push_instr(r_type(7'h00, 5'd10, 5'd10, 3'd0, 5'd11, OP_REG), 1'b1);
        push_instr(r_type(7'h20, 5'd10, 5'd11, 3'd0, 5'd12, OP_REG), 1'b1);
        push_instr(i_type(12'h7ff, 5'd0, 3'd6, 5'd13, OP_IMM), 1'b1);
        drain();
    endtask

    ////////////////////
    // Sequence
    initial begin : main
        int seed;
        seed = 18416;
        void'($urandom(seed));
        arst_n         = 1'b0;
        flush          = 1'b0;
        push           = 1'b0;
        instruction    = '0;
        pc             = '0;
        next_pc        = 32'h0000_1000;
        drops_expected = 0;
        drops_seen     = 0;
        pending        = 0;
        push_count     = 0;
        for (int r = 0; r < 32; r++)
            model_regs[r] = '0;
        repeat (2) @(posedge clk);    // Reset held two cycles
        #1;
        arst_n = 1'b1;

        imm_arith();
        reg_reg_ops();
        upper_and_link();
        non_alu_drops();
        independent_bursts();
        flush_pending();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire
